//--- logic/memStage_config.svh
`ifndef MEMSTAGE_CONFIG_SVH
`define MEMSTAGE_CONFIG_SVH

// Data RAM space, end is exclusive
`define DATA_START 32'h0000_0000
`define DATA_END 32'h0000_3000

// Timer windows, word access only, end is exclusive
`define TIMER0_START 32'h0000_7F00
`define TIMER0_END 32'h0000_7F0C
`define TIMER1_START 32'h0000_7F10
`define TIMER1_END 32'h0000_7F1C
`define TIMER0_RO_WORD 32'h0000_7F08
`define TIMER1_RO_WORD 32'h0000_7F18

// Kernel entry and CP0 constants
`define TEXT_START 32'h0000_3000
`define EPC_RESET `TEXT_START
`define PRID_VALUE 32'h4D45_4D31
`define CP0_REG_SR 5'd12
`define CP0_REG_CAUSE 5'd13
`define CP0_REG_EPC 5'd14
`define CP0_REG_PRID 5'd15

`define DM_WORDS 3072

`endif

//--- logic/isaPkg.sv
package isaPkg;

    // Operation kinds seen by the memory stage
    typedef enum logic [3:0] {
        opNone,
        opLw,
        opLh,
        opLhu,
        opLb,
        opLbu,
        opSw,
        opSh,
        opSb,
        opMfc0,
        opMtc0,
        opEret
    } memOp_t;

    // Exception codes, other upstream codes pass through unchanged
    typedef logic [4:0] excCode_t;

    localparam excCode_t excNone = 5'd0;
    localparam excCode_t excInt = 5'd0;
    localparam excCode_t excAdEL = 5'd4;
    localparam excCode_t excAdES = 5'd5;

    // Request to the pipeline controller
    typedef enum logic [1:0] {
        kctrlNone,
        kctrlKText,
        kctrlReturn
    } kctrl_t;

    function automatic logic isLoad(memOp_t op);
        return op inside {opLw, opLh, opLhu, opLb, opLbu};
    endfunction

    function automatic logic isStore(memOp_t op);
        return op inside {opSw, opSh, opSb};
    endfunction

endpackage

//--- logic/pipePkg.sv
package pipePkg;

    typedef logic [1:0] tNew_t;

    // Bundle from EX/MEM
    typedef struct packed {
        isaPkg::memOp_t op;
        logic [31:0] pc;
        isaPkg::excCode_t exc;
        logic [31:0] aluAddr;
        logic [31:0] rtData;
        logic [4:0] rtNum;
        logic [4:0] rdNum;
        logic [4:0] dstReg;
        logic [31:0] prevResult;
        tNew_t tNew;
    } memIn_t;

    // MEM/WB register contents
    typedef struct packed {
        isaPkg::memOp_t op;
        logic [31:0] pc;
        logic [31:0] memWord;
        logic [1:0] offset;
        logic [4:0] dstReg;
        logic [31:0] wData;
        tNew_t tNew;
    } wbOut_t;

    typedef struct packed {
        logic [31:2] wordAddr;
        logic [3:0] byteEn;
        logic [31:0] wData;
    } dmReq_t;

    typedef struct packed {
        logic [15:0] resv31;
        logic [5:0] im;
        logic [7:0] resv9;
        logic exl;
        logic ie;
    } statusReg_t;

    typedef struct packed {
        logic bd;
        logic [14:0] resv30;
        logic [5:0] ip;
        logic [2:0] resv9;
        logic [4:0] excCode;
        logic [1:0] resv1;
    } causeReg_t;

    // One CP0 word, seen raw or through a register layout
    typedef union packed {
        logic [31:0] raw;
        statusReg_t sr;
        causeReg_t cause;
    } cp0Word_u;

endpackage

//--- logic/storeAlign.sv
`include "memStage_config.svh"

module storeAlign (
    input isaPkg::memOp_t op,
    input logic [31:0] addr,
    input logic [31:0] wData,
    input logic enable,
    output pipePkg::dmReq_t req,
    output logic [1:0] offset,
    output isaPkg::excCode_t exc
);
    import isaPkg::*;

    logic inData;
    logic inTimer;
    logic isReadOnly;
    logic memAccess;
    logic subWord;
    logic misaligned;
    logic badAccess;

    assign offset = addr[1:0];

    // Address space decode
    always_comb begin
        inData = (addr >= `DATA_START) && (addr < `DATA_END);
        inTimer = ((addr >= `TIMER0_START) && (addr < `TIMER0_END))
            || ((addr >= `TIMER1_START) && (addr < `TIMER1_END));
        isReadOnly = (addr == `TIMER0_RO_WORD) || (addr == `TIMER1_RO_WORD);
    end

    always_comb begin
        memAccess = isLoad(op) || isStore(op);
        subWord = op inside {opLh, opLhu, opLb, opLbu, opSh, opSb};
        misaligned = ((op inside {opLw, opSw}) && (addr[1:0] != 2'b00))
            || ((op inside {opLh, opLhu, opSh}) && addr[0]);
        // Timer registers only take whole words
        badAccess = misaligned
            || (subWord && !inData)
            || (!inData && !inTimer)
            || (isStore(op) && isReadOnly);
        if (!memAccess || !badAccess) begin
            exc = excNone;
        end else if (isStore(op)) begin
            exc = excAdES;
        end else begin
            exc = excAdEL;
        end
    end

    // Lane select and data shift
    always_comb begin
        req.wordAddr = addr[31:2];
        req.byteEn = 4'b0000;
        req.wData = wData;
        case (op)
            opSw: begin
                req.byteEn = 4'b1111;
            end
            opSh: begin
                req.byteEn = addr[1] ? 4'b1100 : 4'b0011;
                req.wData = wData << {addr[1], 4'b0000};
            end
            opSb: begin
                req.byteEn = 4'b0001 << addr[1:0];
                req.wData = wData << {addr[1:0], 3'b000};
            end
            default: begin
                req.byteEn = 4'b0000;
            end
        endcase
        // Faulting or cancelled stores never reach the RAM
        if (!enable || (exc != excNone)) begin
            req.byteEn = 4'b0000;
        end
    end

endmodule

//--- logic/coprocessor0.sv
`include "memStage_config.svh"

module coprocessor0 (
    input logic clk,
    input logic reset,
    input logic [31:0] pc,
    input pipePkg::cp0Word_u wData,
    input logic [4:0] regId,
    input isaPkg::memOp_t op,
    input logic bdFlag,
    input logic [5:0] hwInt,
    input isaPkg::excCode_t exc,
    output isaPkg::kctrl_t kctrl,
    output logic isBD,
    output logic [31:2] epc,
    output pipePkg::cp0Word_u rData,
    output logic intTaken
);
    import isaPkg::*;
    import pipePkg::*;

    localparam logic [31:0] epcResetValue = `EPC_RESET;

    statusReg_t sr;
    causeReg_t cause;
    logic [31:2] epcReg;
    logic excTaken;
    logic entry;
    logic [31:0] entryPc;

    // Interrupts are masked while in kernel mode
    assign intTaken = (|(sr.im & hwInt)) && sr.ie && !sr.exl;
    assign excTaken = (exc != excNone);
    // No kernel entry while in reset
    assign entry = (intTaken || excTaken) && !reset;

    // A fault in a delay slot returns to the branch
    assign entryPc = bdFlag ? (pc - 32'd4) : pc;

    assign epc = epcReg;
    assign isBD = entry ? bdFlag : 1'b0;

    always_comb begin
        if (entry) begin
            kctrl = kctrlKText;
        end else if ((op == opEret) && !reset) begin
            kctrl = kctrlReturn;
        end else begin
            kctrl = kctrlNone;
        end
    end

    // MFC0 read port
    always_comb begin
        rData.raw = 32'd0;
        if (op == opMfc0) begin
            case (regId)
                `CP0_REG_SR: rData.sr = sr;
                `CP0_REG_CAUSE: rData.cause = cause;
                `CP0_REG_EPC: rData.raw = {epcReg, 2'b00};
                `CP0_REG_PRID: rData.raw = `PRID_VALUE;
                default: rData.raw = 32'd0;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            sr <= '0;
            sr.im <= 6'b111111;
            sr.ie <= 1'b1;
            cause <= '0;
            epcReg <= epcResetValue[31:2];
        end else begin
            cause.ip <= hwInt;
            if (op == opEret) begin
                sr.exl <= 1'b0;
                cause.excCode <= excNone;
                cause.bd <= 1'b0;
            end else if (entry) begin
                sr.exl <= 1'b1;
                cause.excCode <= intTaken ? excInt : exc;
                cause.bd <= bdFlag;
            end else if ((op == opMtc0) && (regId == `CP0_REG_SR)) begin
                sr.im <= wData.sr.im;
                sr.exl <= wData.sr.exl;
                sr.ie <= wData.sr.ie;
            end
            // EPC
            if (entry) begin
                epcReg <= entryPc[31:2];
            end else if ((op == opMtc0) && (regId == `CP0_REG_EPC)) begin
                epcReg <= wData.raw[31:2];
            end
        end
    end

endmodule

//--- logic/dataMemory.sv
`include "memStage_config.svh"

module dataMemory (
    input logic clk,
    input pipePkg::dmReq_t req,
    output logic [31:0] rData
);
    localparam int addrBits = $clog2(`DM_WORDS);

    logic [31:0] mem [`DM_WORDS];
    logic [addrBits-1:0] index;
    logic inRange;

    assign index = req.wordAddr[addrBits+1:2];

    // Words past the RAM read as zero and ignore writes
    assign inRange = (req.wordAddr < 30'(`DM_WORDS));

    assign rData = inRange ? mem[index] : 32'd0;

    always_ff @(posedge clk) begin
        if (inRange) begin
            for (int b = 0; b < 4; b++) begin
                if (req.byteEn[b]) begin
                    mem[index][8*b +: 8] <= req.wData[8*b +: 8];
                end
            end
        end
    end

endmodule

//--- logic/memStage.sv
`include "memStage_config.svh"

module memStage (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic clr,
    input pipePkg::memIn_t stageIn,
    input logic [4:0] fwdReg,
    input logic [31:0] fwdData,
    input logic [31:0] macroPc,
    input logic bdMacro,
    input logic [5:0] hwInt,
    output pipePkg::wbOut_t wbOut,
    output isaPkg::kctrl_t kctrl,
    output logic [31:2] epc,
    output logic isBD
);
    import isaPkg::*;
    import pipePkg::*;

    logic [31:0] rtUse;
    cp0Word_u cp0Wr;
    cp0Word_u cp0Rd;
    logic intTaken;
    logic storeEnable;
    dmReq_t dmReq;
    logic [1:0] offset;
    excCode_t alignExc;
    excCode_t mergedExc;
    logic [31:0] memWord;
    logic loadInData;
    logic [31:0] loadWord;
    logic [31:0] wbData;
    tNew_t tNewNext;

    // Write-back forwarding into rt
    assign rtUse = ((fwdReg != 5'd0) && (fwdReg == stageIn.rtNum)) ? fwdData : stageIn.rtData;
    assign cp0Wr.raw = rtUse;

    // No store once the instruction is already on its way to the handler
    assign storeEnable = (stageIn.exc == excNone) && !intTaken;

    storeAlign align_i (
        .op(stageIn.op),
        .addr(stageIn.aluAddr),
        .wData(rtUse),
        .enable(storeEnable),
        .req(dmReq),
        .offset(offset),
        .exc(alignExc)
    );

    // Upstream faults are older, so they win
    assign mergedExc = (stageIn.exc != excNone) ? stageIn.exc : alignExc;

    coprocessor0 cp0_i (
        .clk(clk),
        .reset(reset),
        .pc(macroPc),
        .wData(cp0Wr),
        .regId(stageIn.rdNum),
        .op(stageIn.op),
        .bdFlag(bdMacro),
        .hwInt(hwInt),
        .exc(mergedExc),
        .kctrl(kctrl),
        .isBD(isBD),
        .epc(epc),
        .rData(cp0Rd),
        .intTaken(intTaken)
    );

    dataMemory dm_i (
        .clk(clk),
        .req(dmReq),
        .rData(memWord)
    );

    // Timer space has no device behind it here
    assign loadInData = (stageIn.aluAddr >= `DATA_START) && (stageIn.aluAddr < `DATA_END);
    assign loadWord = loadInData ? memWord : 32'd0;

    always_comb begin
        if (stageIn.op == opMfc0) begin
            wbData = cp0Rd.raw;
        end else if (isLoad(stageIn.op)) begin
            wbData = loadWord;
        end else begin
            wbData = stageIn.prevResult;
        end
    end

    assign tNewNext = (stageIn.tNew != 2'd0) ? (stageIn.tNew - 2'd1) : 2'd0;

    // MEM/WB register
    always_ff @(posedge clk) begin
        if (reset || clr) begin
            wbOut <= '0;
            wbOut.op <= opNone;
        end else if (!stall) begin
            wbOut.op <= stageIn.op;
            wbOut.pc <= stageIn.pc;
            wbOut.memWord <= loadWord;
            wbOut.offset <= offset;
            wbOut.dstReg <= stageIn.dstReg;
            wbOut.wData <= wbData;
            wbOut.tNew <= tNewNext;
        end
    end

endmodule

//--- verification/memStageClock.sv
module memStageClock (
    output logic clk
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    // 10 ns period
    always #5 clk = ~clk;

endmodule

//--- verification/memStage_props.sv
module memStage_props (
    input logic clk,
    input logic reset,
    input logic stall,
    input logic clr,
    input isaPkg::kctrl_t kctrl,
    input pipePkg::wbOut_t wbOut
);
    timeunit 1ns;
    timeprecision 100ps;
    import isaPkg::*;

    // No kernel requests while in reset
    assert property (@(posedge clk) reset |-> (kctrl == kctrlNone))
        else $error("kernel control active during reset");

    // Clear empties the MEM/WB register
    assert property (@(posedge clk) clr |=> (wbOut.op == opNone))
        else $error("wbOut op not none after clear");

    // Stall holds the MEM/WB register
    assert property (@(posedge clk) (stall && !clr && !reset) |=> $stable(wbOut))
        else $error("wbOut changed during stall");

endmodule

bind memStage memStage_props props_i (
    .clk(clk),
    .reset(reset),
    .stall(stall),
    .clr(clr),
    .kctrl(kctrl),
    .wbOut(wbOut)
);

//--- verification/memStageTb.sv
`include "memStage_config.svh"

module memStageTb;
    timeunit 1ns;
    timeprecision 100ps;
    import isaPkg::*;
    import pipePkg::*;

    localparam logic [1:0] selPrev = 2'd0;
    localparam logic [1:0] selModel = 2'd1;
    localparam logic [1:0] selConst = 2'd2;

    typedef struct {
        memOp_t op;
        logic [31:0] addr;
        logic [31:0] rtData;
        logic [4:0] rtNum;
        logic [4:0] fwdReg;
        logic [4:0] rd;
        logic [31:0] pc;
        logic bd;
        logic [5:0] hw;
        logic [1:0] sel;
        logic [31:0] expW;
        kctrl_t expK;
        logic [31:0] expEpc;
        logic stall;
        logic clr;
        logic [1:0] tNew;
    } entry_t;

    logic clk;
    logic reset;
    logic stall;
    logic clr;
    memIn_t stageIn;
    logic [4:0] fwdReg;
    logic [31:0] fwdData;
    logic [31:0] macroPc;
    logic bdMacro;
    logic [5:0] hwInt;
    wbOut_t wbOut;
    kctrl_t kctrl;
    logic [31:2] epc;
    logic isBD;

    entry_t tbl[$];
    logic [7:0] modelMem [0:12287];
    integer seed;
    int errors;
    int checks;
    logic tableReady;
    logic [31:0] expWd;
    logic [1:0] expTn;
    logic [1:0] expOff;
    logic [31:0] expEpcReg;
    memOp_t expOp;
    logic [31:0] expPc;
    logic [4:0] expDst;
    logic [31:0] expMem;
    logic expMemValid;

    memStageClock clkGen_i (.clk(clk));

    memStage dut_i (
        .clk(clk), .reset(reset), .stall(stall), .clr(clr), .stageIn(stageIn),
        .fwdReg(fwdReg), .fwdData(fwdData), .macroPc(macroPc), .bdMacro(bdMacro),
        .hwInt(hwInt), .wbOut(wbOut), .kctrl(kctrl), .epc(epc), .isBD(isBD)
    );

    task automatic add(memOp_t op, logic [31:0] addr, logic [31:0] rtData,
            logic [4:0] rtNum, logic [4:0] fwd, logic [4:0] rd, logic [31:0] pc,
            logic bd, logic [5:0] hw, logic [1:0] sel, logic [31:0] expW,
            kctrl_t expK, logic [31:0] expEpc);
        entry_t e;
        e = '{op, addr, rtData, rtNum, fwd, rd, pc, bd, hw, sel, expW, expK, expEpc,
            1'b0, 1'b0, 2'd2};
        tbl.push_back(e);
    endtask

    task automatic setLast(logic st, logic cl, logic [1:0] tn);
        tbl[tbl.size()-1].stall = st;
        tbl[tbl.size()-1].clr = cl;
        tbl[tbl.size()-1].tNew = tn;
    endtask

    task automatic buildTable();
        // Sub-word stores with read-back, random data where rtData is x
        add(opSw, 'h100, 'x, 3, 0, 0, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h3000);
        add(opLw, 'h100, 0, 0, 0, 0, 'h3400, 0, 0, selModel, 0, kctrlNone, 'h3000);
        add(opSh, 'h102, 'x, 3, 3, 0, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h3000);
        add(opLw, 'h100, 0, 0, 0, 0, 'h3400, 0, 0, selModel, 0, kctrlNone, 'h3000);
        add(opSh, 'h100, 'x, 3, 0, 0, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h3000);
        add(opLw, 'h100, 0, 0, 0, 0, 'h3400, 0, 0, selModel, 0, kctrlNone, 'h3000);
        add(opSb, 'h101, 'x, 3, 0, 0, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h3000);
        add(opLb, 'h101, 0, 0, 0, 0, 'h3400, 0, 0, selModel, 0, kctrlNone, 'h3000);
        add(opSb, 'h103, 'x, 3, 3, 0, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h3000);
        add(opLbu, 'h103, 0, 0, 0, 0, 'h3400, 0, 0, selModel, 0, kctrlNone, 'h3000);
        add(opSb, 'h100, 'x, 3, 0, 0, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h3000);
        add(opSb, 'h102, 'x, 3, 0, 0, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h3000);
        add(opLhu, 'h102, 0, 0, 0, 0, 'h3400, 0, 0, selModel, 0, kctrlNone, 'h3000);
        // Register zero is never forwarded
        add(opSw, 'h104, 'x, 0, 0, 0, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h3000);
        add(opLw, 'h104, 0, 0, 0, 0, 'h3400, 0, 0, selModel, 0, kctrlNone, 'h3000);
        // Address exceptions
        add(opLw, 'h101, 0, 0, 0, 0, 'h3500, 0, 0, selModel, 0, kctrlKText, 'h3500);
        add(opMfc0, 0, 0, 0, 0, 13, 'h3400, 0, 0, selConst, 'h10, kctrlNone, 'h3500);
        add(opLh, 'h105, 0, 0, 0, 0, 'h3504, 0, 0, selModel, 0, kctrlKText, 'h3504);
        add(opMfc0, 0, 0, 0, 0, 13, 'h3400, 0, 0, selConst, 'h10, kctrlNone, 'h3504);
        add(opSw, 'h102, 'x, 3, 0, 0, 'h3508, 0, 0, selPrev, 0, kctrlKText, 'h3508);
        add(opMfc0, 0, 0, 0, 0, 13, 'h3400, 0, 0, selConst, 'h14, kctrlNone, 'h3508);
        add(opLw, 'h100, 0, 0, 0, 0, 'h3400, 0, 0, selModel, 0, kctrlNone, 'h3508);
        add(opSb, 'h7F00, 'x, 3, 0, 0, 'h350C, 0, 0, selPrev, 0, kctrlKText, 'h350C);
        add(opMfc0, 0, 0, 0, 0, 13, 'h3400, 0, 0, selConst, 'h14, kctrlNone, 'h350C);
        add(opSw, 'h7F08, 'x, 3, 0, 0, 'h3510, 0, 0, selPrev, 0, kctrlKText, 'h3510);
        add(opMfc0, 0, 0, 0, 0, 13, 'h3400, 0, 0, selConst, 'h14, kctrlNone, 'h3510);
        add(opLw, 'h7F04, 0, 0, 0, 0, 'h3400, 0, 0, selConst, 0, kctrlNone, 'h3510);
        add(opEret, 0, 0, 0, 0, 0, 'h3400, 0, 0, selPrev, 0, kctrlReturn, 'h3510);
        // Interrupts, the second one is blocked by EXL
        add(opNone, 0, 0, 0, 0, 0, 'h3600, 0, 1, selPrev, 0, kctrlKText, 'h3600);
        add(opMfc0, 0, 0, 0, 0, 13, 'h3400, 0, 1, selConst, 'h400, kctrlNone, 'h3600);
        add(opEret, 0, 0, 0, 0, 0, 'h3400, 0, 0, selPrev, 0, kctrlReturn, 'h3600);
        add(opNone, 0, 0, 0, 0, 0, 'h3700, 1, 2, selPrev, 0, kctrlKText, 'h36FC);
        add(opMfc0, 0, 0, 0, 0, 13, 'h3400, 0, 0, selConst, 'h8000_0800, kctrlNone, 'h36FC);
        add(opEret, 0, 0, 0, 0, 0, 'h3400, 0, 0, selPrev, 0, kctrlReturn, 'h36FC);
        // SR mask on line 0, EPC write, PrID
        add(opMtc0, 0, 'hF801, 5, 0, 12, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h36FC);
        add(opNone, 0, 0, 0, 0, 0, 'h3400, 0, 1, selPrev, 0, kctrlNone, 'h36FC);
        add(opMfc0, 0, 0, 0, 0, 12, 'h3400, 0, 1, selConst, 'hF801, kctrlNone, 'h36FC);
        add(opMtc0, 0, 'h3A06, 5, 0, 14, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h3A04);
        add(opMfc0, 0, 0, 0, 0, 14, 'h3400, 0, 0, selConst, 'h3A04, kctrlNone, 'h3A04);
        add(opMfc0, 0, 0, 0, 0, 15, 'h3400, 0, 0, selConst, `PRID_VALUE, kctrlNone, 'h3A04);
        // Stall, clear and tNew saturation
        add(opNone, 0, 0, 0, 0, 0, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h3A04);
        setLast(0, 0, 3);
        add(opNone, 0, 0, 0, 0, 0, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h3A04);
        setLast(1, 0, 2);
        add(opLw, 'h100, 0, 0, 0, 0, 'h3400, 0, 0, selModel, 0, kctrlNone, 'h3A04);
        setLast(0, 1, 2);
        add(opNone, 0, 0, 0, 0, 0, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h3A04);
        setLast(0, 0, 1);
        add(opNone, 0, 0, 0, 0, 0, 'h3400, 0, 0, selPrev, 0, kctrlNone, 'h3A04);
        setLast(0, 0, 0);
    endtask

    task automatic reportMismatch(string name, logic [31:0] got, logic [31:0] exp);
        $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    function automatic logic [31:0] modelWord(logic [31:0] addr);
        logic [31:0] base;
        base = {addr[31:2], 2'b00};
        if (addr >= `DATA_END) begin
            return 32'd0;
        end
        return {modelMem[base+3], modelMem[base+2], modelMem[base+1], modelMem[base]};
    endfunction

    task automatic applyEntry(entry_t e);
        logic [31:0] rtVal;
        logic [31:0] prev;
        logic [4:0] dst;
        logic [31:0] stored;
        logic [31:0] base;
        int lane;
        int n;
        rtVal = $isunknown(e.rtData) ? $random(seed) : e.rtData;
        fwdData = $random(seed);
        prev = $random(seed);
        dst = $random(seed);
        stageIn = '0;
        stageIn.op = e.op;
        stageIn.pc = e.pc;
        stageIn.aluAddr = e.addr;
        stageIn.rtData = rtVal;
        stageIn.rtNum = e.rtNum;
        stageIn.rdNum = e.rd;
        stageIn.dstReg = dst;
        stageIn.prevResult = prev;
        stageIn.tNew = e.tNew;
        fwdReg = e.fwdReg;
        macroPc = e.pc;
        bdMacro = e.bd;
        hwInt = e.hw;
        stall = e.stall;
        clr = e.clr;
        stored = ((e.fwdReg != 0) && (e.fwdReg == e.rtNum)) ? fwdData : rtVal;
        // Expected MEM/WB contents after the next edge
        if (e.clr) begin
            expWd = 0;
            expTn = 0;
            expOff = 0;
            expOp = opNone;
            expPc = 0;
            expDst = 0;
            expMem = 0;
            expMemValid = 1'b1;
        end else if (!e.stall) begin
            case (e.sel)
                selModel: expWd = modelWord(e.addr);
                selConst: expWd = e.expW;
                default: expWd = prev;
            endcase
            expTn = (e.tNew == 0) ? 2'd0 : e.tNew - 2'd1;
            expOff = e.addr[1:0];
            expOp = e.op;
            expPc = e.pc;
            expDst = dst;
            // Memory word is only known for loads
            expMem = modelWord(e.addr);
            expMemValid = isLoad(e.op);
        end
        expEpcReg = e.expEpc;
        // Reference memory takes only stores that do not trap
        if (isStore(e.op) && (e.expK == kctrlNone) && (e.addr < `DATA_END)) begin
            base = {e.addr[31:2], 2'b00};
            n = (e.op == opSw) ? 4 : (e.op == opSh) ? 2 : 1;
            lane = (e.op == opSw) ? 0 : (e.op == opSh) ? {e.addr[1], 1'b0} : e.addr[1:0];
            for (int k = 0; k < n; k++) begin
                modelMem[base+lane+k] = stored[8*k +: 8];
            end
        end
    endtask

    task automatic checkComb(entry_t e);
        logic expBd;
        expBd = (e.expK == kctrlKText) ? e.bd : 1'b0;
        checks += 2;
        if (kctrl !== e.expK) reportMismatch("kctrl", kctrl, e.expK);
        if (isBD !== expBd) reportMismatch("isBD", isBD, expBd);
    endtask

    task automatic checkRegistered();
        checks += 7;
        if (wbOut.op !== expOp) reportMismatch("wbOut.op", wbOut.op, expOp);
        if (wbOut.pc !== expPc) reportMismatch("wbOut.pc", wbOut.pc, expPc);
        if (wbOut.dstReg !== expDst) reportMismatch("wbOut.dstReg", wbOut.dstReg, expDst);
        if (wbOut.wData !== expWd) reportMismatch("wbOut.wData", wbOut.wData, expWd);
        if (wbOut.tNew !== expTn) reportMismatch("wbOut.tNew", wbOut.tNew, expTn);
        if (wbOut.offset !== expOff) reportMismatch("wbOut.offset", wbOut.offset, expOff);
        if ({epc, 2'b00} !== expEpcReg) reportMismatch("epc", {epc, 2'b00}, expEpcReg);
        if (expMemValid) begin
            checks++;
            if (wbOut.memWord !== expMem) begin
                reportMismatch("wbOut.memWord", wbOut.memWord, expMem);
            end
        end
    endtask

    initial begin
        tableReady = 1'b0;
        wait (tableReady);
        #((tbl.size() + 20) * 10);
        $display("timeout: the test table did not finish in time");
        $display("TB FAILED");
        $finish;
    end

    initial begin
        seed = 2165;
        errors = 0;
        checks = 0;
        expMemValid = 1'b0;
        reset = 1'b1;
        stall = 1'b0;
        clr = 1'b0;
        stageIn = '0;
        fwdReg = '0;
        fwdData = '0;
        macroPc = '0;
        bdMacro = 1'b0;
        // Pending interrupt line while in reset
        hwInt = 6'b000001;
        buildTable();
        tableReady = 1'b1;
        repeat (8) @(posedge clk);
        #1 reset = 1'b0;
        hwInt = '0;
        for (int i = 0; i <= tbl.size(); i++) begin
            @(posedge clk);
            #1;
            if (i > 0) checkRegistered();
            if (i < tbl.size()) begin
                applyEntry(tbl[i]);
                #4;
                checkComb(tbl[i]);
            end
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- memStage.f
+incdir+logic
logic/isaPkg.sv
logic/pipePkg.sv
logic/storeAlign.sv
logic/coprocessor0.sv
logic/dataMemory.sv
logic/memStage.sv
verification/memStageClock.sv
verification/memStage_props.sv
verification/memStageTb.sv

//--- Bender.yml
package:
  name: memStage

sources:
  - include_dirs:
      - logic
    files:
      - logic/isaPkg.sv
      - logic/pipePkg.sv
      - logic/storeAlign.sv
      - logic/coprocessor0.sv
      - logic/dataMemory.sv
      - logic/memStage.sv
  - target: simulation
    include_dirs:
      - logic
    files:
      - verification/memStageClock.sv
      - verification/memStage_props.sv
      - verification/memStageTb.sv
